//--- dv/tb_conv_weight_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_weight_top import cnn_accel_pkg::*;;

    logic                        clk;
    logic                        rst;
    logic                        config_mode;
    logic                        wht_config_wren;
    logic [WEIGHT_WIDTH-1:0]     wht_config_data;
    logic                        kernel_config_valid;
    logic [15:0]                 kernel_full_count;
    logic                        act_wren;
    logic [ACT_WIDTH-1:0]        act_data;
    logic                        job_start;
    logic                        result_valid;
    logic signed [ACC_WIDTH-1:0] result_data;
    logic                        result_last;
    logic                        busy;

    // Reference data and scoreboard
    logic signed [WEIGHT_WIDTH-1:0] wts [64][TAPS_PER_KERNEL];
    logic signed [ACT_WIDTH-1:0]    acts [TAPS_PER_KERNEL];
    logic signed [ACC_WIDTH-1:0]    exp_sum [64];
    logic [31:0]                    rng_state = 32'd9754;
    string                          test_name = "reset";
    int                             expected_count = 0;
    int                             result_idx = 0;
    int                             value_errors = 0;
    int                             protocol_errors = 0;
    int                             timeout_errors = 0;

    conv_weight_top #(.SEQ_ADDR_DELAY(3)) conv_weight_top_inst (
        .clk (clk), .rst (rst), .config_mode (config_mode),
        .wht_config_wren (wht_config_wren), .wht_config_data (wht_config_data),
        .kernel_config_valid (kernel_config_valid), .kernel_full_count (kernel_full_count),
        .act_wren (act_wren), .act_data (act_data), .job_start (job_start),
        .result_valid (result_valid), .result_data (result_data),
        .result_last (result_last), .busy (busy)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Signed sum of nine weight times activation products
    function automatic logic signed [ACC_WIDTH-1:0] dot_product(input int g);
        logic signed [ACC_WIDTH-1:0] sum;
        sum = '0;
        for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
            sum = sum + wts[g][t] * acts[t];
        end
        return sum;
    endfunction

    task automatic randomize_weights(input int n_kernels, input bit negative);
        for (int g = 0; g < n_kernels; g++) begin
            for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
                wts[g][t] = xorshift32() >> 7;
                if (negative) begin
                    wts[g][t][WEIGHT_WIDTH-1] = 1'b1;
                end
            end
        end
    endtask

    task automatic randomize_acts(input bit negative);
        for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
            acts[t] = xorshift32() >> 11;
            // Taps 0, 3 and 6 stay positive so both lanes see negative products
            if (negative && (t % 3 != 0)) begin
                acts[t][ACT_WIDTH-1] = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    // Weights in kernel order then the window and the last group
    task automatic load_config(input int n_kernels);
        @(posedge clk);
        config_mode <= 1'b1;
        for (int g = 0; g < n_kernels; g++) begin
            for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
                @(posedge clk);
                wht_config_wren <= 1'b1;
                wht_config_data <= wts[g][t];
            end
        end
        @(posedge clk);
        wht_config_wren <= 1'b0;
        for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
            act_wren <= 1'b1;
            act_data <= acts[t];
            @(posedge clk);
        end
        act_wren <= 1'b0;
        // Upper bits are ignored by the loader
        kernel_config_valid <= 1'b1;
        kernel_full_count   <= {10'h155, 6'(n_kernels - 1)};
        @(posedge clk);
        kernel_config_valid <= 1'b0;
        config_mode         <= 1'b0;
        for (int g = 0; g < n_kernels; g++) begin
            exp_sum[g] = dot_product(g);
        end
    endtask

    task automatic run_job(input string name, input int n_kernels);
        int cycles;
        test_name      = name;
        expected_count = n_kernels;
        @(posedge clk);
        job_start  <= 1'b1;
        result_idx <= 0;
        @(posedge clk);
        job_start <= 1'b0;
        cycles = 0;
        while (!busy && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("timeout in %s: busy never rose after job_start", name);
            timeout_errors++;
        end
        cycles = 0;
        while (result_idx < n_kernels && cycles < 200 * n_kernels) begin
            @(posedge clk);
            cycles++;
        end
        if (result_idx < n_kernels) begin
            $display("timeout in %s: only %0d of %0d results arrived",
                     name, result_idx, n_kernels);
            timeout_errors++;
        end
        cycles = 0;
        while (busy && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (busy) begin
            $display("timeout in %s: busy stayed high after the last result", name);
            timeout_errors++;
        end
        // Quiet window where the monitor catches late results
        cycles = 0;
        while (cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    // Outputs quiet through reset and one cycle after it
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!result_valid && !result_last && !busy))
        else begin
            $display("reset check failed: result or busy active during or after reset");
            protocol_errors++;
        end

    // No result once the sequencer has been idle for three cycles
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (!busy && $past(!busy) && $past(!busy, 2)) |-> !result_valid)
        else begin
            $display("idle check failed in %s: result_valid rose while idle", test_name);
            protocol_errors++;
        end

    // Results in group order against the scoreboard
    always @(posedge clk) begin
        if (!rst && result_valid) begin
            if (result_idx >= expected_count) begin
                $display("unexpected result in %s beyond the %0d expected",
                         test_name, expected_count);
                protocol_errors++;
            end else begin
                assert (result_data == exp_sum[result_idx])
                    else begin
                        $display("error %s kernel %0d: expected %0d, actual %0d",
                                 test_name, result_idx, exp_sum[result_idx], result_data);
                        value_errors++;
                    end
                assert (result_last == (result_idx == expected_count - 1))
                    else begin
                        $display("error %s kernel %0d last flag: expected %0b, actual %0b",
                                 test_name, result_idx,
                                 result_idx == expected_count - 1, result_last);
                        value_errors++;
                    end
            end
            result_idx <= result_idx + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        config_mode         = 1'b0;
        wht_config_wren     = 1'b0;
        wht_config_data     = '0;
        kernel_config_valid = 1'b0;
        kernel_full_count   = '0;
        act_wren            = 1'b0;
        act_data            = '0;
        job_start           = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // One kernel, last group 0
        randomize_weights(1, 1'b0);
        randomize_acts(1'b0);
        load_config(1);
        run_job("single_kernel", 1);

        // Six kernels in group order
        randomize_weights(6, 1'b0);
        load_config(6);
        run_job("multi_kernel", 6);

        // Negative values with kernel 5 at full negative scale
        randomize_weights(6, 1'b1);
        randomize_acts(1'b1);
        for (int t = 0; t < TAPS_PER_KERNEL; t++) begin
            wts[5][t] = 16'h8000;
        end
        load_config(6);
        run_job("signed_sums", 6);

        // Same table again from group 0
        run_job("repeat_job", 6);

        // Fresh weights and a shorter kernel list
        randomize_weights(4, 1'b0);
        randomize_acts(1'b0);
        load_config(4);
        run_job("reconfigure", 4);

        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cnn_accel_pkg.sv
`default_nettype none

package cnn_accel_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////////////////////////
    localparam int WEIGHT_WIDTH = 16;
    localparam int ACT_WIDTH = 16;
    // Wide enough for nine 32-bit products with headroom
    localparam int ACC_WIDTH = 40;

    //////////////////////////////////////////////////////////////////////
    // Kernel and weight table geometry
    //////////////////////////////////////////////////////////////////////
    // 3x3 kernel
    localparam int TAPS_PER_KERNEL = 9;
    // Tap index, also low part of the table address
    localparam int TAP_ADDR_WIDTH = 4;
    localparam int GROUP_WIDTH = 6;
    localparam int RAM_ADDR_WIDTH = GROUP_WIDTH + TAP_ADDR_WIDTH;
    localparam int RAM_DEPTH = 1 << RAM_ADDR_WIDTH;
    // Array register plus output register
    localparam int RAM_READ_LATENCY = 2;
    // Two taps per cycle, odd lane idle on the last pair
    localparam int PAIRS_PER_KERNEL = 5;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        GAP,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/config_loader.sv
`timescale 1ns/1ps
`default_nettype none

module config_loader import cnn_accel_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   config_mode,
    input  logic                   kernel_config_valid,
    input  logic [15:0]            kernel_full_count,
    input  logic                   act_wren,
    input  logic [ACT_WIDTH-1:0]   act_data,
    input  logic                   job_start,
    output logic                   job_accept,
    output logic [GROUP_WIDTH-1:0] last_group,
    output logic [ACT_WIDTH-1:0]   act_window0,
    output logic [ACT_WIDTH-1:0]   act_window1,
    output logic [ACT_WIDTH-1:0]   act_window2,
    output logic [ACT_WIDTH-1:0]   act_window3,
    output logic [ACT_WIDTH-1:0]   act_window4,
    output logic [ACT_WIDTH-1:0]   act_window5,
    output logic [ACT_WIDTH-1:0]   act_window6,
    output logic [ACT_WIDTH-1:0]   act_window7,
    output logic [ACT_WIDTH-1:0]   act_window8
);

    localparam int IDX_WIDTH = $clog2(TAPS_PER_KERNEL);
    localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(TAPS_PER_KERNEL - 1);

    logic [IDX_WIDTH-1:0] act_idx;
    logic [ACT_WIDTH-1:0] act_q [TAPS_PER_KERNEL];

    // Control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            job_accept <= 1'b0;
            last_group <= '0;
            act_idx    <= '0;
        end else begin
            // Jobs are refused while loading
            job_accept <= job_start && !config_mode;
            if (kernel_config_valid) begin
                last_group <= kernel_full_count[GROUP_WIDTH-1:0];
            end
            if (job_accept) begin
                act_idx <= '0;
            end else if (act_wren) begin
                act_idx <= (act_idx == LAST_IDX) ? '0 : act_idx + 1'b1;
            end
        end
    end

    // Activation window, held for the whole job
    always_ff @(posedge clk) begin
        if (act_wren) begin
            act_q[act_idx] <= act_data;
        end
    end

    assign act_window0 = act_q[0];
    assign act_window1 = act_q[1];
    assign act_window2 = act_q[2];
    assign act_window3 = act_q[3];
    assign act_window4 = act_q[4];
    assign act_window5 = act_q[5];
    assign act_window6 = act_q[6];
    assign act_window7 = act_q[7];
    assign act_window8 = act_q[8];

endmodule

`default_nettype wire

//--- rtl/conv_weight_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_weight_top import cnn_accel_pkg::*; #(
    parameter int SEQ_ADDR_DELAY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        config_mode,
    input  logic                        wht_config_wren,
    input  logic [WEIGHT_WIDTH-1:0]     wht_config_data,
    input  logic                        kernel_config_valid,
    input  logic [15:0]                 kernel_full_count,
    input  logic                        act_wren,
    input  logic [ACT_WIDTH-1:0]        act_data,
    input  logic                        job_start,
    output logic                        result_valid,
    output logic signed [ACC_WIDTH-1:0] result_data,
    output logic                        result_last,
    output logic                        busy
);

    logic                      job_accept;
    logic [GROUP_WIDTH-1:0]    last_group;
    logic [ACT_WIDTH-1:0]      act_window [TAPS_PER_KERNEL];
    logic                      ce_execute;
    logic [TAP_ADDR_WIDTH-1:0] wht_seq_addr0;
    logic [TAP_ADDR_WIDTH-1:0] wht_seq_addr1;
    logic                      next_kernel;
    logic [2*WEIGHT_WIDTH-1:0] wht_table_dout;
    logic                      wht_table_dout_valid;
    logic                      last_kernel;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////
    config_loader config_loader_inst (
        .clk (clk), .rst (rst), .config_mode (config_mode),
        .kernel_config_valid (kernel_config_valid), .kernel_full_count (kernel_full_count),
        .act_wren (act_wren), .act_data (act_data), .job_start (job_start),
        .job_accept (job_accept), .last_group (last_group),
        .act_window0 (act_window[0]), .act_window1 (act_window[1]),
        .act_window2 (act_window[2]), .act_window3 (act_window[3]),
        .act_window4 (act_window[4]), .act_window5 (act_window[5]),
        .act_window6 (act_window[6]), .act_window7 (act_window[7]),
        .act_window8 (act_window[8])
    );

    //////////////////////////////////////////////////////////////////////
    // Weight path
    //////////////////////////////////////////////////////////////////////
    // Pair index output left open, the MAC counts pairs itself
    kernel_sequencer #(.SEQ_ADDR_DELAY(SEQ_ADDR_DELAY)) kernel_sequencer_inst (
        .clk (clk), .rst (rst), .job_accept (job_accept), .last_group (last_group),
        .ce_execute (ce_execute), .ce_cycle_counter (),
        .wht_seq_addr0 (wht_seq_addr0), .wht_seq_addr1 (wht_seq_addr1),
        .next_kernel (next_kernel), .busy (busy)
    );

    weight_table #(.SEQ_ADDR_DELAY(SEQ_ADDR_DELAY)) weight_table_inst (
        .clk (clk), .rst (rst), .config_mode (config_mode), .job_accept (job_accept),
        .next_kernel (next_kernel), .last_group (last_group),
        .wht_config_wren (wht_config_wren), .wht_config_data (wht_config_data),
        .wht_seq_addr0 (wht_seq_addr0), .wht_seq_addr1 (wht_seq_addr1),
        .ce_execute (ce_execute), .wht_table_dout (wht_table_dout),
        .wht_table_dout_valid (wht_table_dout_valid), .last_kernel (last_kernel)
    );

    // Output side
    kernel_mac kernel_mac_inst (
        .clk (clk), .rst (rst), .wht_table_dout (wht_table_dout),
        .wht_table_dout_valid (wht_table_dout_valid), .last_kernel (last_kernel),
        .act_window0 (act_window[0]), .act_window1 (act_window[1]),
        .act_window2 (act_window[2]), .act_window3 (act_window[3]),
        .act_window4 (act_window[4]), .act_window5 (act_window[5]),
        .act_window6 (act_window[6]), .act_window7 (act_window[7]),
        .act_window8 (act_window[8]),
        .result_valid (result_valid), .result_data (result_data), .result_last (result_last)
    );

endmodule

`default_nettype wire

//--- rtl/kernel_mac.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_mac import cnn_accel_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [2*WEIGHT_WIDTH-1:0]     wht_table_dout,
    input  logic                          wht_table_dout_valid,
    input  logic                          last_kernel,
    input  logic [ACT_WIDTH-1:0]          act_window0,
    input  logic [ACT_WIDTH-1:0]          act_window1,
    input  logic [ACT_WIDTH-1:0]          act_window2,
    input  logic [ACT_WIDTH-1:0]          act_window3,
    input  logic [ACT_WIDTH-1:0]          act_window4,
    input  logic [ACT_WIDTH-1:0]          act_window5,
    input  logic [ACT_WIDTH-1:0]          act_window6,
    input  logic [ACT_WIDTH-1:0]          act_window7,
    input  logic [ACT_WIDTH-1:0]          act_window8,
    output logic                          result_valid,
    output logic signed [ACC_WIDTH-1:0]   result_data,
    output logic                          result_last
);

    localparam int PAIR_WIDTH = $clog2(PAIRS_PER_KERNEL);
    localparam logic [PAIR_WIDTH-1:0] LAST_PAIR = PAIR_WIDTH'(PAIRS_PER_KERNEL - 1);

    logic signed [WEIGHT_WIDTH-1:0]           wht0;
    logic signed [WEIGHT_WIDTH-1:0]           wht1;
    logic signed [ACT_WIDTH-1:0]              act [TAPS_PER_KERNEL];
    logic signed [WEIGHT_WIDTH+ACT_WIDTH-1:0] prod0;
    logic signed [WEIGHT_WIDTH+ACT_WIDTH-1:0] prod1_raw;
    logic signed [WEIGHT_WIDTH+ACT_WIDTH-1:0] prod1;
    logic signed [ACC_WIDTH-1:0]              acc_q;
    logic signed [ACC_WIDTH-1:0]              acc_sum;
    logic [PAIR_WIDTH-1:0]                    pair_q;

    // Window indexed by tap
    assign act[0] = act_window0;
    assign act[1] = act_window1;
    assign act[2] = act_window2;
    assign act[3] = act_window3;
    assign act[4] = act_window4;
    assign act[5] = act_window5;
    assign act[6] = act_window6;
    assign act[7] = act_window7;
    assign act[8] = act_window8;

    //////////////////////////////////////////////////////////////////////
    // Two-lane multiply and running sum
    //////////////////////////////////////////////////////////////////////
    assign wht0 = wht_table_dout[WEIGHT_WIDTH-1:0];
    assign wht1 = wht_table_dout[2*WEIGHT_WIDTH-1:WEIGHT_WIDTH];
    assign prod0 = wht0 * act[{pair_q, 1'b0}];
    assign prod1_raw = wht1 * act[{pair_q, 1'b1}];
    // Odd lane has no tap on the last pair
    assign prod1 = (pair_q == LAST_PAIR) ? '0 : prod1_raw;
    assign acc_sum = acc_q + prod0 + prod1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_q       <= '0;
            acc_q        <= '0;
            result_valid <= 1'b0;
            result_last  <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            result_last  <= 1'b0;
            if (wht_table_dout_valid) begin
                if (pair_q == LAST_PAIR) begin
                    // Fifth pair closes the kernel
                    result_data  <= acc_sum;
                    result_valid <= 1'b1;
                    result_last  <= last_kernel;
                    acc_q        <= '0;
                    pair_q       <= '0;
                end else begin
                    acc_q  <= acc_sum;
                    pair_q <= pair_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/kernel_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_sequencer import cnn_accel_pkg::*; #(
    parameter int SEQ_ADDR_DELAY = 3
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 job_accept,
    input  logic [GROUP_WIDTH-1:0]               last_group,
    output logic                                 ce_execute,
    output logic [$clog2(PAIRS_PER_KERNEL)-1:0]  ce_cycle_counter,
    output logic [TAP_ADDR_WIDTH-1:0]            wht_seq_addr0,
    output logic [TAP_ADDR_WIDTH-1:0]            wht_seq_addr1,
    output logic                                 next_kernel,
    output logic                                 busy
);

    localparam int PAIR_WIDTH = $clog2(PAIRS_PER_KERNEL);
    localparam logic [PAIR_WIDTH-1:0] LAST_PAIR = PAIR_WIDTH'(PAIRS_PER_KERNEL - 1);
    // Table group update delay plus margin
    localparam int GAP_CYCLES = SEQ_ADDR_DELAY + RAM_READ_LATENCY + 2;
    localparam int GAP_WIDTH = $clog2(GAP_CYCLES);
    localparam logic [GAP_WIDTH-1:0] GAP_LAST = GAP_WIDTH'(GAP_CYCLES - 1);

    seq_state_t             state;
    logic [PAIR_WIDTH-1:0]  pair_q;
    logic [GAP_WIDTH-1:0]   gap_q;
    logic [GROUP_WIDTH-1:0] kernel_q;

    //////////////////////////////////////////////////////////////////////
    // Kernel walk
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            pair_q           <= '0;
            gap_q            <= '0;
            kernel_q         <= '0;
            ce_execute       <= 1'b0;
            ce_cycle_counter <= '0;
            wht_seq_addr0    <= '0;
            wht_seq_addr1    <= '0;
            next_kernel      <= 1'b0;
        end else begin
            ce_execute  <= 1'b0;
            next_kernel <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_accept) begin
                        state    <= ISSUE;
                        pair_q   <= '0;
                        kernel_q <= '0;
                    end
                end
                ISSUE: begin
                    // Even tap on lane 0, odd tap on lane 1
                    ce_execute       <= 1'b1;
                    ce_cycle_counter <= pair_q;
                    wht_seq_addr0    <= {pair_q, 1'b0};
                    wht_seq_addr1    <= {pair_q, 1'b1};
                    if (pair_q == LAST_PAIR) begin
                        state  <= GAP;
                        pair_q <= '0;
                        gap_q  <= '0;
                    end else begin
                        pair_q <= pair_q + 1'b1;
                    end
                end
                GAP: begin
                    // Pulse right after the last pair
                    next_kernel <= (gap_q == '0);
                    gap_q       <= gap_q + 1'b1;
                    if (gap_q == GAP_LAST) begin
                        if (kernel_q == last_group) begin
                            state <= DONE;
                        end else begin
                            state    <= ISSUE;
                            kernel_q <= kernel_q + 1'b1;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- rtl/shift_delay.sv
`timescale 1ns/1ps
`default_nettype none

module shift_delay #(
    parameter int DELAY = 3,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // One register per stage of delay
    logic [WIDTH-1:0] stage [DELAY];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            // Shift toward the output end
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DELAY-1];

endmodule

`default_nettype wire

//--- rtl/weight_ram_dp.sv
`timescale 1ns/1ps
`default_nettype none

module weight_ram_dp import cnn_accel_pkg::*; (
    input  logic                      clk,
    input  logic [RAM_ADDR_WIDTH-1:0] addr_a,
    input  logic                      wren_a,
    input  logic [WEIGHT_WIDTH-1:0]   din_a,
    input  logic                      rden_a,
    output logic [WEIGHT_WIDTH-1:0]   dout_a,
    input  logic [RAM_ADDR_WIDTH-1:0] addr_b,
    input  logic                      rden_b,
    output logic [WEIGHT_WIDTH-1:0]   dout_b
);

    logic [WEIGHT_WIDTH-1:0] mem [RAM_DEPTH];
    // First read stage, one per port
    logic [WEIGHT_WIDTH-1:0] ram_a;
    logic [WEIGHT_WIDTH-1:0] ram_b;

    //////////////////////////////////////////////////////////////////////
    // Port A, write or read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wren_a) begin
            // No-change mode, read stage holds its value
            mem[addr_a] <= din_a;
        end else if (rden_a) begin
            ram_a <= mem[addr_a];
        end
        dout_a <= ram_a;
    end

    //////////////////////////////////////////////////////////////////////
    // Port B, read only
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rden_b) begin
            ram_b <= mem[addr_b];
        end
        dout_b <= ram_b;
    end

endmodule

`default_nettype wire

//--- rtl/weight_table.sv
`timescale 1ns/1ps
`default_nettype none

module weight_table import cnn_accel_pkg::*; #(
    parameter int SEQ_ADDR_DELAY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        config_mode,
    input  logic                        job_accept,
    input  logic                        next_kernel,
    input  logic [GROUP_WIDTH-1:0]      last_group,
    input  logic                        wht_config_wren,
    input  logic [WEIGHT_WIDTH-1:0]     wht_config_data,
    input  logic [TAP_ADDR_WIDTH-1:0]   wht_seq_addr0,
    input  logic [TAP_ADDR_WIDTH-1:0]   wht_seq_addr1,
    input  logic                        ce_execute,
    output logic [2*WEIGHT_WIDTH-1:0]   wht_table_dout,
    output logic                        wht_table_dout_valid,
    output logic                        last_kernel
);

    localparam logic [TAP_ADDR_WIDTH-1:0] LAST_TAP = TAP_ADDR_WIDTH'(TAPS_PER_KERNEL - 1);

    logic [GROUP_WIDTH-1:0]    group_q;
    logic [TAP_ADDR_WIDTH-1:0] tap_q;
    logic [RAM_ADDR_WIDTH-1:0] addr0_w;
    logic [RAM_ADDR_WIDTH-1:0] addr1_w;
    logic [RAM_ADDR_WIDTH-1:0] addr0_d;
    logic [RAM_ADDR_WIDTH-1:0] addr1_d;
    logic [RAM_ADDR_WIDTH-1:0] addr_a;
    logic                      wren_a;
    logic                      rden;
    logic                      next_kernel_d;
    logic                      last_flag;
    logic [1:0]                flags_d;
    logic [WEIGHT_WIDTH-1:0]   dout0;
    logic [WEIGHT_WIDTH-1:0]   dout1;

    //////////////////////////////////////////////////////////////////////
    // Address build and delay
    //////////////////////////////////////////////////////////////////////
    // Current group selects the kernel, sequencer picks the tap
    assign addr0_w = {group_q, wht_seq_addr0};
    assign addr1_w = {group_q, wht_seq_addr1};

    shift_delay #(.DELAY(SEQ_ADDR_DELAY), .WIDTH(RAM_ADDR_WIDTH)) addr0_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (addr0_w),
        .dout (addr0_d)
    );

    shift_delay #(.DELAY(SEQ_ADDR_DELAY), .WIDTH(RAM_ADDR_WIDTH)) addr1_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (addr1_w),
        .dout (addr1_d)
    );

    // Read enable travels with the addresses
    shift_delay #(.DELAY(SEQ_ADDR_DELAY), .WIDTH(1)) rden_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (ce_execute),
        .dout (rden)
    );

    // Group moves only once the last read of the kernel is out
    shift_delay #(.DELAY(SEQ_ADDR_DELAY + RAM_READ_LATENCY), .WIDTH(1)) next_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (next_kernel),
        .dout (next_kernel_d)
    );

    // Valid and last flag follow the RAM read pipe
    assign last_flag = (group_q == last_group) && !config_mode;

    shift_delay #(.DELAY(RAM_READ_LATENCY), .WIDTH(2)) flag_dly (
        .clk  (clk),
        .rst  (rst),
        .din  ({rden, last_flag}),
        .dout (flags_d)
    );

    assign wht_table_dout_valid = flags_d[1];
    assign last_kernel = flags_d[0];

    //////////////////////////////////////////////////////////////////////
    // Weight store
    //////////////////////////////////////////////////////////////////////
    // Port A writes during config, reads lane 0 during a job
    assign addr_a = config_mode ? {group_q, tap_q} : addr0_d;
    assign wren_a = wht_config_wren && config_mode;

    weight_ram_dp ram_inst (
        .clk    (clk),
        .addr_a (addr_a),
        .wren_a (wren_a),
        .din_a  (wht_config_data),
        .rden_a (rden),
        .dout_a (dout0),
        .addr_b (addr1_d),
        .rden_b (rden),
        .dout_b (dout1)
    );

    // Lane 1 in the upper half
    assign wht_table_dout = {dout1, dout0};

    // Tap and group counters
    always_ff @(posedge clk) begin
        if (rst || job_accept) begin
            tap_q   <= '0;
            group_q <= '0;
        end else if (wren_a) begin
            if (tap_q == LAST_TAP) begin
                tap_q   <= '0;
                group_q <= group_q + 1'b1;
            end else begin
                tap_q <= tap_q + 1'b1;
            end
        end else if (next_kernel_d) begin
            // Wrap after the last configured kernel
            group_q <= (group_q == last_group) ? '0 : group_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cnn_accel_pkg.sv
rtl/shift_delay.sv
rtl/weight_ram_dp.sv
rtl/weight_table.sv
rtl/config_loader.sv
rtl/kernel_sequencer.sv
rtl/kernel_mac.sv
rtl/conv_weight_top.sv
dv/tb_conv_weight_top.sv
